// ==== quad_corr_top.f ====
+incdir+hw
hw/corr_pkg.sv
hw/corr_sq_bus_if.sv
hw/corr_tap_align.sv
hw/corr_add_square.sv
hw/corr_beat_counter.sv
hw/corr_window_fsm.sv
hw/corr_power_accum.sv
hw/quad_corr_top.sv
testbench/corr_checker.sv
testbench/tb_quad_corr.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the correlator testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -Wno-fatal -f quad_corr_top.f --top-module tb_quad_corr \
	-Mdir obj_dir -o sim_quad_corr
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_quad_corr > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
	exit 0
fi
echo "Pass line not found in $LOG"
exit 1

// ==== testbench/corr_testdata.txt ====
# Header: type flags stray_a stray_b stray_c ped0 ped1 ped2 ped3 exp0 exp1 exp2 exp3 (hex)
# Then eight beats of a, of b and of c; flag bit 0 adds an idle beat, bit 1 a second start
0 0 000 000 000 000 000 000 000 120 11B 118 113
249 249 249 249 249 249 249 249
249 249 249 249 249 249 249 249
249 249 249 249 249 249 249 249
1 2 000 000 000 000 000 000 000 020 023 026 032
492 492 492 492 492 492 492 492
FFF FFF FFF FFF FFF FFF FFF FFF
DB6 DB6 DB6 DB6 DB6 DB6 DB6 DB6
2 1 000 6DB 924 000 000 000 000 020 02F 023 03B
FFF FFF FFF FFF FFF FFF FFF FFF
000 000 000 000 000 000 000 000
492 492 492 492 492 492 492 492
0 0 000 000 000 000 1F4 FFF 0C8 FFF FA0 175 FFF
924 924 924 924 924 924 924 924
924 924 924 924 924 924 924 924
924 924 924 924 924 924 924 924
1 2 000 000 000 010 100 030 014 010 000 000 044
249 249 249 249 249 249 249 249
000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000

// ==== testbench/tb_quad_corr.sv ====
`timescale 1ns/1ps

// Testbench for quad_corr_top, windows read from a data file.
module tb_quad_corr;

	localparam int RESET_CYCLES = 8;
	// Bound on the wait for done_o after the last beat.
	localparam int DONE_TIMEOUT = 100;
	// Longest idle gap before a beat.
	localparam int MAX_GAP = 3;
	localparam int BEATS = 8;

	logic clk;
	logic arst_n;
	logic start;
	logic valid;
	corr_pkg::corr_type_e corr_type;
	logic [11:0] a;
	logic [11:0] b;
	logic [11:0] c;
	logic ped_load;
	logic [47:0] ped;
	logic done;
	logic [11:0] corr0;
	logic [11:0] corr1;
	logic [11:0] corr2;
	logic [11:0] corr3;

	// Checker side.
	logic exp_load;
	logic [47:0] exp_val;
	logic last_beat;
	int done_cnt;
	int value_errs;
	int timing_errs;
	int protocol_errs;

	// Current window record.
	corr_pkg::corr_type_e type_w;
	int flags_w;
	logic [11:0] stray_w [3];
	logic [11:0] ped_w [4];
	logic [11:0] exp_w [4];
	logic [11:0] beat_w [3][BEATS];

	int fd;
	int setup_errs = 0;
	int timeout_errs = 0;
	int windows = 0;

	quad_corr_top UUT (
		.clk(clk), .arst_n_i(arst_n),
		.start_i(start), .valid_i(valid), .corr_type_i(corr_type),
		.a_i(a), .b_i(b), .c_i(c),
		.ped_load_i(ped_load), .ped_i(ped),
		.done_o(done),
		.corr0_o(corr0), .corr1_o(corr1), .corr2_o(corr2), .corr3_o(corr3)
	);

	corr_checker u_checker (
		.clk(clk), .arst_n_i(arst_n),
		.valid_i(valid), .last_beat_i(last_beat),
		.exp_load_i(exp_load), .exp_i(exp_val),
		.done_i(done),
		.corr0_i(corr0), .corr1_i(corr1), .corr2_i(corr2), .corr3_i(corr3),
		.done_cnt_o(done_cnt), .value_errs_o(value_errs),
		.timing_errs_o(timing_errs), .protocol_errs_o(protocol_errs)
	);

	// 4 ns clock.
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Next line that is neither a comment nor blank.
	task automatic next_data_line(output string line, output bit found);
		int n;
		bit eof;
		found = 1'b0;
		eof = 1'b0;
		line = "";
		while (!found && !eof) begin
			n = $fgets(line, fd);
			if (n <= 0)
				eof = 1'b1;
			else if (line.getc(0) != "#" && line.getc(0) != "\n")
				found = 1'b1;
		end
	endtask

	// Header line, then one line of eight beats for each of a, b and c.
	task automatic read_window(output bit got);
		string line;
		bit found;
		int type_val;
		int n;
		got = 1'b0;
		next_data_line(line, found);
		if (!found)
			return;
		n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h", type_val, flags_w,
			stray_w[0], stray_w[1], stray_w[2], ped_w[0], ped_w[1], ped_w[2], ped_w[3],
			exp_w[0], exp_w[1], exp_w[2], exp_w[3]);
		if (n != 13) begin
			$display("Malformed window header in the data file: %s", line);
			setup_errs++;
			return;
		end
		type_w = corr_pkg::corr_type_e'(type_val[1:0]);
		for (int ch = 0; ch < 3; ch++) begin
			next_data_line(line, found);
			n = 0;
			if (found)
				n = $sscanf(line, "%h %h %h %h %h %h %h %h", beat_w[ch][0], beat_w[ch][1],
					beat_w[ch][2], beat_w[ch][3], beat_w[ch][4], beat_w[ch][5],
					beat_w[ch][6], beat_w[ch][7]);
			if (n != BEATS) begin
				$display("Missing or short beat line for channel %0d in window %0d",
					ch, windows + 1);
				setup_errs++;
				return;
			end
		end
		got = 1'b1;
	endtask

	// Pedestals, optional idle beat, start, then eight beats with random gaps.
	task automatic play_window();
		int gap;
		@(negedge clk);
		ped = {ped_w[3], ped_w[2], ped_w[1], ped_w[0]};
		ped_load = 1'b1;
		@(negedge clk);
		ped_load = 1'b0;
		// Beat in IDLE, it only feeds the history.
		if (flags_w[0]) begin
			valid = 1'b1;
			a = stray_w[0];
			b = stray_w[1];
			c = stray_w[2];
			@(negedge clk);
			valid = 1'b0;
		end
		corr_type = type_w;
		start = 1'b1;
		exp_load = 1'b1;
		exp_val = {exp_w[3], exp_w[2], exp_w[1], exp_w[0]};
		@(negedge clk);
		start = 1'b0;
		exp_load = 1'b0;
		for (int j = 0; j < BEATS; j++) begin
			gap = int'($urandom % (MAX_GAP + 1));
			repeat (gap) @(negedge clk);
			valid = 1'b1;
			a = beat_w[0][j];
			b = beat_w[1][j];
			c = beat_w[2][j];
			last_beat = (j == BEATS - 1);
			// Second start in RUN, to be ignored.
			start = flags_w[1] && (j == 3);
			@(negedge clk);
			valid = 1'b0;
			last_beat = 1'b0;
			start = 1'b0;
		end
	endtask

	task automatic wait_for_done(input int target, output bit timed_out);
		int waited;
		waited = 0;
		while (done_cnt < target && waited < DONE_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		timed_out = (done_cnt < target);
	endtask

	initial begin
		int unsigned seed_val;
		bit got;
		bit timed_out;
		bit stop;
		int total;
		$timeformat(-9, 0, " ns", 0);
		seed_val = $urandom(32'h6542);
		arst_n = 1'b0;
		start = 1'b0;
		valid = 1'b0;
		corr_type = corr_pkg::TYPEA;
		a = '0;
		b = '0;
		c = '0;
		ped_load = 1'b0;
		ped = '0;
		exp_load = 1'b0;
		exp_val = '0;
		last_beat = 1'b0;
		stop = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		arst_n = 1'b1;
		// Quiet cycles, done_o must stay low.
		repeat (4) @(negedge clk);
		fd = $fopen("testbench/corr_testdata.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the data file testbench/corr_testdata.txt");
			setup_errs++;
			stop = 1'b1;
		end
		while (!stop) begin
			read_window(got);
			if (!got) begin
				stop = 1'b1;
			end else begin
				windows++;
				play_window();
				wait_for_done(windows, timed_out);
				if (timed_out) begin
					$display("Timeout, done_o did not arrive within %0d cycles in window %0d",
						DONE_TIMEOUT, windows);
					timeout_errs++;
					stop = 1'b1;
				end
			end
		end
		if (fd != 0)
			$fclose(fd);
		if (windows == 0 && setup_errs == 0) begin
			$display("No window records found in the data file");
			setup_errs++;
		end
		repeat (4) @(negedge clk);
		total = value_errs + timing_errs + protocol_errs + timeout_errs + setup_errs;
		$display("Errors: value %0d, timing %0d, protocol %0d, timeout %0d, setup %0d",
			value_errs, timing_errs, protocol_errs, timeout_errs, setup_errs);
		if (total == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== testbench/corr_checker.sv ====
`timescale 1ns/1ps

// Scoreboard for the correlator results and the done_o timing.
module corr_checker (
	input  logic        clk,
	input  logic        arst_n_i,
	input  logic        valid_i,
	input  logic        last_beat_i,
	input  logic        exp_load_i,
	input  logic [47:0] exp_i,
	input  logic        done_i,
	input  logic [11:0] corr0_i,
	input  logic [11:0] corr1_i,
	input  logic [11:0] corr2_i,
	input  logic [11:0] corr3_i,
	output int          done_cnt_o,
	output int          value_errs_o,
	output int          timing_errs_o,
	output int          protocol_errs_o
);

	// Cycles from the eighth beat to the rise of done_o.
	localparam int DONE_LATENCY = 3;

	// Expected results of the open windows in start order.
	logic [47:0] exp_q [$];
	logic [3:0][11:0] got;

	int cycle_cnt = 0;
	int last_beat_cycle = -1;
	int done_cnt = 0;
	int value_errs = 0;
	int timing_errs = 0;
	int protocol_errs = 0;

	assign got = {corr3_i, corr2_i, corr1_i, corr0_i};

	assign done_cnt_o      = done_cnt;
	assign value_errs_o    = value_errs;
	assign timing_errs_o   = timing_errs;
	assign protocol_errs_o = protocol_errs;

	// DUT outputs read here still hold the values from before this edge.
	always @(posedge clk) begin
		logic [47:0] exp_v;
		int latency;
		cycle_cnt++;
		if (arst_n_i) begin
			if (exp_load_i)
				exp_q.push_back(exp_i);
			// Edge on which the DUT takes the eighth beat.
			if (valid_i && last_beat_i)
				last_beat_cycle = cycle_cnt;
			if (done_i) begin
				done_cnt++;
				// Edges from the beat to the first edge that sees done_o.
				latency = cycle_cnt - last_beat_cycle;
				if (exp_q.size() == 0) begin
					$display("Unexpected done_o at %0t with no window open", $time);
					protocol_errs++;
				end else begin
					exp_v = exp_q.pop_front();
					if (latency != DONE_LATENCY) begin
						$display("Error at %0t: done_o came %0d cycles after the last beat, expected %0d",
							$time, latency, DONE_LATENCY);
						timing_errs++;
					end
					// Correlation k sits in bits 12k upward.
					for (int k = 0; k < 4; k++) begin
						if (got[k] !== exp_v[12*k +: 12]) begin
							$display("Error at %0t: corr%0d_o is %0d, expected %0d",
								$time, k, got[k], exp_v[12*k +: 12]);
							value_errs++;
						end
					end
				end
			end
		end
	end

endmodule

// ==== hw/quad_corr_top.sv ====
`timescale 1ns/1ps
`include "corr_consts.svh"

module quad_corr_top (
	input  logic                       clk,
	input  logic                       arst_n_i,
	input  logic                       start_i,
	input  logic                       valid_i,
	input  corr_pkg::corr_type_e       corr_type_i,
	input  logic [`CORR_CH_BITS-1:0]   a_i,
	input  logic [`CORR_CH_BITS-1:0]   b_i,
	input  logic [`CORR_CH_BITS-1:0]   c_i,
	input  logic                       ped_load_i,
	input  logic [`CORR_NCORRS*`CORR_POWER_BITS-1:0] ped_i,
	output logic                       done_o,
	output logic [`CORR_POWER_BITS-1:0] corr0_o,
	output logic [`CORR_POWER_BITS-1:0] corr1_o,
	output logic [`CORR_POWER_BITS-1:0] corr2_o,
	output logic [`CORR_POWER_BITS-1:0] corr3_o
);

	// Tap stage to add-and-square stage.
	logic [`CORR_NCORRS-1:0][2:0][`CORR_SAMPLES-1:0][`CORR_IN_BITS-1:0] aligned;
	logic tap_valid;
	logic tap_in_window;

	// FSM and counter.
	logic in_window;
	logic cnt_load;
	logic [`CORR_CNT_BITS-1:0] cnt_val;
	logic cnt_dec;
	logic cnt_zero;
	logic acc_clear;
	logic acc_dump;

	logic [`CORR_NCORRS-1:0][`CORR_POWER_BITS-1:0] corr;

	corr_sq_bus_if sq_bus ();

	corr_tap_align u_tap_align (
		.clk(clk), .arst_n_i(arst_n_i),
		.valid_i(valid_i), .in_window_i(in_window), .corr_type_i(corr_type_i),
		.a_i(a_i), .b_i(b_i), .c_i(c_i),
		.aligned_o(aligned), .in_window_o(tap_in_window), .valid_o(tap_valid)
	);

	corr_add_square u_add_square (
		.clk(clk), .arst_n_i(arst_n_i),
		.aligned_i(aligned), .valid_i(tap_valid), .in_window_i(tap_in_window),
		.sq_bus(sq_bus.source)
	);

	corr_beat_counter u_beat_counter (
		.clk(clk), .arst_n_i(arst_n_i),
		.load_i(cnt_load), .load_val_i(cnt_val), .dec_i(cnt_dec), .zero_o(cnt_zero)
	);

	corr_window_fsm u_window_fsm (
		.clk(clk), .arst_n_i(arst_n_i),
		.start_i(start_i), .valid_i(valid_i), .cnt_zero_i(cnt_zero),
		.cnt_load_o(cnt_load), .cnt_val_o(cnt_val), .cnt_dec_o(cnt_dec),
		.acc_clear_o(acc_clear), .acc_dump_o(acc_dump), .in_window_o(in_window)
	);

	corr_power_accum u_power_accum (
		.clk(clk), .arst_n_i(arst_n_i),
		.sq_bus(sq_bus.sink), .acc_clear_i(acc_clear), .acc_dump_i(acc_dump),
		.ped_load_i(ped_load_i), .ped_i(ped_i),
		.corr_o(corr), .done_o(done_o)
	);

	assign corr0_o = corr[0];
	assign corr1_o = corr[1];
	assign corr2_o = corr[2];
	assign corr3_o = corr[3];

endmodule

// ==== hw/corr_power_accum.sv ====
`timescale 1ns/1ps
`include "corr_consts.svh"

module corr_power_accum (
	input  logic                       clk,
	input  logic                       arst_n_i,
	corr_sq_bus_if.sink                sq_bus,
	input  logic                       acc_clear_i,
	input  logic                       acc_dump_i,
	input  logic                       ped_load_i,
	input  logic [`CORR_NCORRS*`CORR_POWER_BITS-1:0] ped_i,
	output logic [`CORR_NCORRS-1:0][`CORR_POWER_BITS-1:0] corr_o,
	output logic                       done_o
);

	logic [`CORR_NCORRS-1:0][`CORR_ACC_BITS-1:0] acc_q;
	// Correlation k sits in bits 12k upward, same as the bus.
	logic [`CORR_NCORRS-1:0][`CORR_POWER_BITS-1:0] ped_q;
	// Accumulator including the beat on the bus this cycle.
	logic [`CORR_NCORRS-1:0][`CORR_ACC_BITS-1:0] acc_sum;
	// One extra bit so a pedestal above the sum shows as negative.
	logic [`CORR_NCORRS-1:0][`CORR_ACC_BITS:0] diff;
	logic [`CORR_NCORRS-1:0][`CORR_POWER_BITS-1:0] clamped;

	always_comb begin
		for (int k = 0; k < `CORR_NCORRS; k++) begin
			acc_sum[k] = acc_q[k];
			if (sq_bus.sq_valid)
				acc_sum[k] = acc_q[k] + `CORR_ACC_BITS'(sq_bus.beat_sum[k]);
			diff[k] = {1'b0, acc_sum[k]} - (`CORR_ACC_BITS + 1)'(ped_q[k]);
			// Clamp to 0..4095.
			if (diff[k][`CORR_ACC_BITS])
				clamped[k] = '0;
			else if (diff[k][`CORR_ACC_BITS-1:`CORR_POWER_BITS] != '0)
				clamped[k] = '1;
			else
				clamped[k] = diff[k][`CORR_POWER_BITS-1:0];
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			acc_q  <= '0;
			ped_q  <= '0;
			corr_o <= '0;
			done_o <= 1'b0;
		end else begin
			if (acc_clear_i)
				acc_q <= '0;
			else
				acc_q <= acc_sum;
			if (ped_load_i)
				ped_q <= ped_i;
			// Results hold until the next dump.
			if (acc_dump_i)
				corr_o <= clamped;
			done_o <= acc_dump_i;
		end
	end

endmodule

// ==== hw/corr_window_fsm.sv ====
`timescale 1ns/1ps
`include "corr_consts.svh"

module corr_window_fsm (
	input  logic                      clk,
	input  logic                      arst_n_i,
	input  logic                      start_i,
	input  logic                      valid_i,
	input  logic                      cnt_zero_i,
	output logic                      cnt_load_o,
	output logic [`CORR_CNT_BITS-1:0] cnt_val_o,
	output logic                      cnt_dec_o,
	output logic                      acc_clear_o,
	output logic                      acc_dump_o,
	output logic                      in_window_o
);

	corr_pkg::win_state_e state_q;
	corr_pkg::win_state_e state_d;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i)
			state_q <= corr_pkg::IDLE;
		else
			state_q <= state_d;
	end

	always_comb begin
		state_d     = state_q;
		cnt_load_o  = 1'b0;
		cnt_val_o   = `CORR_CNT_BITS'(`CORR_WINDOW - 1);
		cnt_dec_o   = 1'b0;
		acc_clear_o = 1'b0;
		acc_dump_o  = 1'b0;
		case (state_q)
			// Start is only honoured here.
			corr_pkg::IDLE: begin
				if (start_i) begin
					cnt_load_o  = 1'b1;
					acc_clear_o = 1'b1;
					state_d     = corr_pkg::RUN;
				end
			end
			// Counter at zero on a beat means the eighth beat.
			corr_pkg::RUN: begin
				if (valid_i) begin
					if (cnt_zero_i) begin
						cnt_load_o = 1'b1;
						cnt_val_o  = `CORR_CNT_BITS'(`CORR_DRAIN - 1);
						state_d    = corr_pkg::DRAIN;
					end else begin
						cnt_dec_o = 1'b1;
					end
				end
			end
			// Dump lands on the cycle the last beat sum arrives.
			corr_pkg::DRAIN: begin
				if (cnt_zero_i) begin
					acc_dump_o = 1'b1;
					state_d    = corr_pkg::IDLE;
				end else begin
					cnt_dec_o = 1'b1;
				end
			end
			default: state_d = corr_pkg::IDLE;
		endcase
	end

	assign in_window_o = (state_q == corr_pkg::RUN);

endmodule

// ==== hw/corr_beat_counter.sv ====
`timescale 1ns/1ps
`include "corr_consts.svh"

module corr_beat_counter (
	input  logic                      clk,
	input  logic                      arst_n_i,
	input  logic                      load_i,
	input  logic [`CORR_CNT_BITS-1:0] load_val_i,
	input  logic                      dec_i,
	output logic                      zero_o
);

	logic [`CORR_CNT_BITS-1:0] count_q;

	// Load wins over decrement, and the count stops at zero.
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i)
			count_q <= '0;
		else if (load_i)
			count_q <= load_val_i;
		else if (dec_i && count_q != '0)
			count_q <= count_q - 1'b1;
	end

	// Loaded with N-1, so zero marks the Nth event.
	assign zero_o = (count_q == '0);

endmodule

// ==== hw/corr_add_square.sv ====
`timescale 1ns/1ps
`include "corr_consts.svh"

module corr_add_square (
	input  logic                 clk,
	input  logic                 arst_n_i,
	input  logic [`CORR_NCORRS-1:0][2:0][`CORR_SAMPLES-1:0][`CORR_IN_BITS-1:0] aligned_i,
	input  logic                 valid_i,
	input  logic                 in_window_i,
	corr_sq_bus_if.source        sq_bus
);

	// Square of each slot of each correlation.
	logic [`CORR_NCORRS-1:0][`CORR_SAMPLES-1:0][`CORR_SQ_BITS-1:0] sq;
	// Sum of the four squares of a beat.
	logic [`CORR_NCORRS-1:0][`CORR_BEAT_BITS-1:0] beat_total;

	for (genvar k = 0; k < `CORR_NCORRS; k++) begin : g_corr
		for (genvar s = 0; s < `CORR_SAMPLES; s++) begin : g_slot
			// A+B+C spans -12 to 9, held at square width so the product fits.
			logic signed [`CORR_SQ_BITS-1:0] tri_sum;

			assign tri_sum = $signed(aligned_i[k][0][s]) + $signed(aligned_i[k][1][s])
				+ $signed(aligned_i[k][2][s]);
			// Square is at most 144 and reads as unsigned.
			assign sq[k][s] = tri_sum * tri_sum;
		end
	end

	always_comb begin
		for (int k = 0; k < `CORR_NCORRS; k++) begin
			beat_total[k] = '0;
			for (int s = 0; s < `CORR_SAMPLES; s++)
				beat_total[k] = beat_total[k] + `CORR_BEAT_BITS'(sq[k][s]);
		end
	end

	// Only beats tagged in-window reach the accumulator.
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i)
			sq_bus.sq_valid <= 1'b0;
		else
			sq_bus.sq_valid <= valid_i & in_window_i;
	end

	always_ff @(posedge clk) begin
		if (valid_i)
			sq_bus.beat_sum <= beat_total;
	end

endmodule

// ==== hw/corr_tap_align.sv ====
`timescale 1ns/1ps
`include "corr_consts.svh"

module corr_tap_align (
	input  logic                       clk,
	input  logic                       arst_n_i,
	input  logic                       valid_i,
	input  logic                       in_window_i,
	input  corr_pkg::corr_type_e       corr_type_i,
	input  logic [`CORR_CH_BITS-1:0]   a_i,
	input  logic [`CORR_CH_BITS-1:0]   b_i,
	input  logic [`CORR_CH_BITS-1:0]   c_i,
	output logic [`CORR_NCORRS-1:0][2:0][`CORR_SAMPLES-1:0][`CORR_IN_BITS-1:0] aligned_o,
	output logic                       in_window_o,
	output logic                       valid_o
);

	// Last sample of B from the previous beat.
	logic [`CORR_IN_BITS-1:0] b_last;
	// Last two samples of C, previous slot 2 in the low bits.
	logic [2*`CORR_IN_BITS-1:0] c_last;
	// Type held for the whole window.
	corr_pkg::corr_type_e type_q;

	// Channel views by delay in samples.
	logic [1:0][`CORR_CH_BITS-1:0] b_view;
	logic [2:0][`CORR_CH_BITS-1:0] c_view;

	// Per-correlation delays of B and C.
	logic [`CORR_NCORRS-1:0] b_dly;
	logic [`CORR_NCORRS-1:0][1:0] c_dly;

	// History runs on every beat, window or not.
	// The type follows the input until the window opens, so it is the value seen at start.
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			b_last      <= '0;
			c_last      <= '0;
			type_q      <= corr_pkg::TYPEA;
			valid_o     <= 1'b0;
			in_window_o <= 1'b0;
		end else begin
			if (valid_i) begin
				b_last <= b_i[`CORR_CH_BITS-1 -: `CORR_IN_BITS];
				c_last <= c_i[`CORR_CH_BITS-1 -: 2*`CORR_IN_BITS];
			end
			if (!in_window_i)
				type_q <= corr_type_i;
			valid_o     <= valid_i;
			in_window_o <= in_window_i;
		end
	end

	// A delay of d moves every slot d places later and fills from history.
	assign b_view[0] = b_i;
	assign b_view[1] = {b_i[0 +: `CORR_CH_BITS-`CORR_IN_BITS], b_last};
	assign c_view[0] = c_i;
	assign c_view[1] = {c_i[0 +: `CORR_CH_BITS-`CORR_IN_BITS], c_last[`CORR_IN_BITS +: `CORR_IN_BITS]};
	assign c_view[2] = {c_i[0 +: `CORR_CH_BITS-2*`CORR_IN_BITS], c_last};

	// Offset tables, correlation 3 in the top entry.
	always_comb begin
		case (type_q)
			corr_pkg::TYPEB: begin
				b_dly = 4'b1000;
				c_dly = {2'd2, 2'd2, 2'd1, 2'd0};
			end
			corr_pkg::TYPEC: begin
				b_dly = 4'b1110;
				c_dly = {2'd2, 2'd1, 2'd0, 2'd0};
			end
			// TYPEA, and the unused code.
			default: begin
				b_dly = 4'b1100;
				c_dly = {2'd2, 2'd1, 2'd1, 2'd0};
			end
		endcase
	end

	// Aligned sets, A is never delayed.
	always_ff @(posedge clk) begin
		if (valid_i) begin
			for (int k = 0; k < `CORR_NCORRS; k++) begin
				aligned_o[k][0] <= a_i;
				aligned_o[k][1] <= b_view[b_dly[k]];
				aligned_o[k][2] <= c_view[c_dly[k]];
			end
		end
	end

endmodule

// ==== hw/corr_sq_bus_if.sv ====
`timescale 1ns/1ps
`include "corr_consts.svh"

// Per-beat sums of squares, one per correlation.
interface corr_sq_bus_if;

	// High for one cycle per in-window beat.
	logic sq_valid;
	// Beat totals, correlation k in entry k.
	logic [`CORR_NCORRS-1:0][`CORR_BEAT_BITS-1:0] beat_sum;

	// Add-and-square stage side.
	modport source (
		output sq_valid,
		output beat_sum
	);

	// Accumulator side.
	modport sink (
		input sq_valid,
		input beat_sum
	);

endinterface

// ==== hw/corr_pkg.sv ====
package corr_pkg;

	// Offset set chosen at runtime.
	// TYPEA is 0/0/0, 0/0/-1, 0/-1/-1, 0/-1/-2.
	// TYPEB is 0/0/0, 0/0/-1, 0/0/-2, 0/-1/-2.
	// TYPEC is 0/0/0, 0/-1/0, 0/-1/-1, 0/-1/-2.
	typedef enum logic [1:0] {
		TYPEA = 2'd0,
		TYPEB = 2'd1,
		TYPEC = 2'd2
	} corr_type_e;

	// Integration window states.
	// RUN counts the window beats.
	// DRAIN waits for the pipeline to deliver the last beat.
	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		RUN   = 2'd1,
		DRAIN = 2'd2
	} win_state_e;

endpackage

// ==== hw/corr_consts.svh ====
`ifndef CORR_CONSTS_SVH
`define CORR_CONSTS_SVH

// Samples per beat on each channel, slot 0 is the earliest.
`define CORR_SAMPLES    (4)
// Signed sample width.
`define CORR_IN_BITS    (3)
// One channel bus per beat.
`define CORR_CH_BITS    (12)
`define CORR_NCORRS     (4)
// Largest square is (-12)^2 = 144.
`define CORR_SQ_BITS    (8)
// Four squares per beat, at most 576.
`define CORR_BEAT_BITS  (10)
// Eight beats per window, at most 4608.
`define CORR_ACC_BITS   (13)
`define CORR_POWER_BITS (12)
`define CORR_WINDOW     (8)
// Cycles between the last window beat and the dump.
`define CORR_DRAIN      (2)
`define CORR_CNT_BITS   (4)

`endif
